// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f compile.f --top-module tb_decode_stage

run: compile
	@out=$$(./obj_dir/Vtb_decode_stage); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

// File: compile.f
isa_pkg.sv
ctrl_pkg.sv
control_decoder.sv
reg_file.sv
imm_extend.sv
decode_stage.sv
tb_decode_stage.sv

// File: control_decoder.sv
`default_nettype none

module control_decoder (
  input  wire isa_pkg::opcode_e opcode,
  output ctrl_pkg::alu_op_e     alu_op,
  output ctrl_pkg::sext_e       sext,
  output logic                  src2_imm,
  output logic                  alu_int,
  output logic                  reg_id_sel,
  output logic                  mem_read,
  output logic                  mem_write,
  output logic                  wb_mem,
  output logic                  wb_pred,
  output logic                  wb_greg
);

  // operation select
  always_comb
  begin
    alu_op = ctrl_pkg::ALU_NONE;
    case (opcode)
      isa_pkg::LD, isa_pkg::ST: alu_op = ctrl_pkg::ALU_ADD; // address calc
      isa_pkg::ADDI, isa_pkg::ADD: alu_op = ctrl_pkg::ALU_ADD;
      isa_pkg::SUBI, isa_pkg::SUB: alu_op = ctrl_pkg::ALU_SUB;
      isa_pkg::MULI, isa_pkg::MUL: alu_op = ctrl_pkg::ALU_MUL;
      isa_pkg::DIVI, isa_pkg::DIV: alu_op = ctrl_pkg::ALU_DIV;
      isa_pkg::MODI, isa_pkg::MOD: alu_op = ctrl_pkg::ALU_MOD;
      isa_pkg::SHLI, isa_pkg::SHL: alu_op = ctrl_pkg::ALU_SHL;
      isa_pkg::SHRI, isa_pkg::SHR: alu_op = ctrl_pkg::ALU_SHR;
      isa_pkg::ANDI, isa_pkg::AND: alu_op = ctrl_pkg::ALU_AND;
      isa_pkg::ORI, isa_pkg::OR: alu_op = ctrl_pkg::ALU_OR;
      isa_pkg::XORI, isa_pkg::XOR: alu_op = ctrl_pkg::ALU_XOR;
      isa_pkg::NEG: alu_op = ctrl_pkg::ALU_NEG;
      isa_pkg::NOT: alu_op = ctrl_pkg::ALU_NOT;
      isa_pkg::LDI: alu_op = ctrl_pkg::ALU_PASS;
      // predicate unit reuses codes 1..7
      isa_pkg::ANDP: alu_op = ctrl_pkg::ALU_ADD; // andp
      isa_pkg::ORP: alu_op = ctrl_pkg::ALU_SUB; // orp
      isa_pkg::XORP: alu_op = ctrl_pkg::ALU_MUL; // xorp
      isa_pkg::NOTP: alu_op = ctrl_pkg::ALU_DIV; // notp
      isa_pkg::RTOP: alu_op = ctrl_pkg::ALU_MOD; // rtop
      isa_pkg::ISNEG: alu_op = ctrl_pkg::ALU_SHL; // isneg
      isa_pkg::ISZERO: alu_op = ctrl_pkg::ALU_SHR; // iszero
      default: alu_op = ctrl_pkg::ALU_NONE;
    endcase
  end

  // operand, memory and writeback flags
  always_comb
  begin
    sext       = ctrl_pkg::SEXT_NONE;
    src2_imm   = 1'b0;
    alu_int    = 1'b0;
    reg_id_sel = 1'b0;
    mem_read   = 1'b0;
    mem_write  = 1'b0;
    wb_mem     = 1'b0;
    wb_pred    = 1'b0;
    wb_greg    = 1'b0;
    case (opcode)
      isa_pkg::LD:
      begin
        src2_imm = 1'b1;
        alu_int  = 1'b1;
        sext     = ctrl_pkg::SEXT_15;
        mem_read = 1'b1;
        wb_mem   = 1'b1; // result from memory
        wb_greg  = 1'b1;
      end
      isa_pkg::ST:
      begin
        src2_imm   = 1'b1;
        alu_int    = 1'b1;
        sext       = ctrl_pkg::SEXT_15;
        mem_write  = 1'b1;
        reg_id_sel = 1'b1; // store data sits in z field
      end
      isa_pkg::ANDP, isa_pkg::ORP, isa_pkg::XORP, isa_pkg::NOTP,
      isa_pkg::RTOP, isa_pkg::ISNEG, isa_pkg::ISZERO:
      begin
        wb_pred = 1'b1;
      end
      isa_pkg::LDI:
      begin
        src2_imm = 1'b1;
        alu_int  = 1'b1;
        sext     = ctrl_pkg::SEXT_19;
        wb_greg  = 1'b1;
      end
      isa_pkg::ADDI, isa_pkg::SUBI, isa_pkg::MULI, isa_pkg::DIVI, isa_pkg::MODI,
      isa_pkg::SHLI, isa_pkg::SHRI, isa_pkg::ANDI, isa_pkg::ORI, isa_pkg::XORI:
      begin
        src2_imm = 1'b1;
        alu_int  = 1'b1;
        sext     = ctrl_pkg::SEXT_15;
        wb_greg  = 1'b1;
      end
      isa_pkg::AND, isa_pkg::OR, isa_pkg::XOR, isa_pkg::ADD, isa_pkg::SUB,
      isa_pkg::MUL, isa_pkg::DIV, isa_pkg::MOD, isa_pkg::SHL, isa_pkg::SHR,
      isa_pkg::NEG, isa_pkg::NOT:
      begin
        alu_int = 1'b1;
        wb_greg = 1'b1;
      end
      default:
      begin
        wb_greg = 1'b0; // float and undefined opcodes act as nop
      end
    endcase
  end

endmodule

`default_nettype wire

// File: ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

  // with alu_int low, codes 1..7 are the predicate/test ops:
  // andp orp xorp notp rtop isneg iszero
  typedef enum logic [3:0] {
    ALU_NONE = 4'd0,
    ALU_ADD  = 4'd1,
    ALU_SUB  = 4'd2,
    ALU_MUL  = 4'd3,
    ALU_DIV  = 4'd4,
    ALU_MOD  = 4'd5,
    ALU_SHL  = 4'd6,
    ALU_SHR  = 4'd7,
    ALU_AND  = 4'd8,
    ALU_OR   = 4'd9,
    ALU_XOR  = 4'd10,
    ALU_NEG  = 4'd11,
    ALU_NOT  = 4'd12,
    ALU_PASS = 4'd13
  } alu_op_e;

  typedef enum logic [1:0] {
    SEXT_NONE = 2'd0,
    SEXT_15   = 2'd1,
    SEXT_23   = 2'd2,
    SEXT_19   = 2'd3
  } sext_e;

endpackage

`default_nettype wire

// File: decode_cases.mem
// inst gwe gwid gwdata pwe pwid pwdata rst  alu_op flags imm rx ry px py pval
// flags bits 6..0: src2_imm alu_int mem_read mem_write wb_mem wb_pred wb_greg
12981234 1 3 12345678 0 0 0 0  d 61 00001234 00000000 00000000 0 0 1
128ffff0 1 5 cafe0001 1 1 1 0  d 61 fffffff0 00000000 00000000 0 0 1
053a9800 0 0 00000000 0 0 0 0  1 21 00000000 12345678 cafe0001 0 1 1
12298810 0 0 00000000 0 0 0 0  1 68 00000810 cafe0001 12345678 1 0 1
1191fffc 0 0 00000000 0 0 0 0  1 75 fffffffc 00000000 12345678 0 0 1
0a229005 0 0 00000000 0 0 0 0  1 61 00001005 00000000 cafe0001 0 1 1
0a88c000 0 0 00000000 0 0 0 0  2 61 ffffc000 00000000 00000000 0 1 1
08818ff0 0 0 00000000 0 0 0 0  8 61 00000ff0 00000000 12345678 1 0 1
0d002805 0 0 00000000 0 0 0 0  7 61 00002805 cafe0001 00000000 1 0 1
08019800 0 0 00000000 0 0 0 0  7 21 00000000 12345678 12345678 0 0 1
0382a800 0 0 00000000 0 0 0 0  8 21 00000000 cafe0001 cafe0001 1 1 1
02801800 0 0 00000000 0 0 0 0  b 21 00000000 12345678 00000000 0 0 1
0301a800 0 0 00000000 0 0 0 0  c 21 00000000 cafe0001 12345678 1 0 1
b3810800 0 0 00000000 1 2 1 0  1 02 00000000 00000000 00000000 1 0 1
d4019000 0 0 00000000 1 1 0 0  2 02 00000000 00000000 12345678 1 0 1
b4810800 0 0 00000000 0 0 0 0  3 02 00000000 00000000 00000000 0 1 0
35008800 0 0 00000000 0 0 0 0  4 02 00000000 00000000 00000000 0 0 1
f3011000 0 0 00000000 0 0 0 0  5 02 00000000 00000000 00000000 1 1 0
1581a800 0 0 00000000 0 0 0 0  6 02 00000000 cafe0001 12345678 0 0 1
d6000000 0 0 00000000 0 0 0 0  7 02 00000000 00000000 00000000 0 0 1
0d829800 0 0 00000000 0 0 0 0  0 00 00000000 12345678 cafe0001 0 0 1
1f801800 0 0 00000000 0 0 0 0  0 00 00000000 12345678 00000000 0 0 1
05019800 1 3 deadbeef 1 3 1 0  1 21 00000000 12345678 12345678 0 0 1
05019800 0 0 00000000 0 0 0 0  1 21 00000000 deadbeef deadbeef 1 1 1
05019800 1 5 11111111 0 0 0 1  1 21 00000000 deadbeef deadbeef 1 1 1
e5029800 0 0 00000000 0 0 0 0  1 21 00000000 00000000 00000000 0 0 0

// File: decode_stage.sv
`default_nettype none

module decode_stage (
  input  wire                       clk,
  input  wire                       rst,
  input  wire isa_pkg::word_t       inst,
  input  wire                       greg_we,
  input  wire isa_pkg::greg_id_t    greg_wid,
  input  wire isa_pkg::word_t       greg_wdata,
  input  wire                       preg_we,
  input  wire isa_pkg::preg_id_t    preg_wid,
  input  wire                       preg_wdata,
  output isa_pkg::word_t            rx,
  output isa_pkg::word_t            ry,
  output logic                      px,
  output logic                      py,
  output logic                      pval,
  output isa_pkg::greg_id_t         rz_id,
  output isa_pkg::word_t            imm,
  output ctrl_pkg::alu_op_e         alu_op,
  output logic                      src2_imm,
  output logic                      alu_int,
  output logic                      mem_read,
  output logic                      mem_write,
  output logic                      wb_mem,
  output logic                      wb_pred,
  output logic                      wb_greg
);

  isa_pkg::opcode_e  opcode;
  isa_pkg::greg_id_t x_id;
  isa_pkg::greg_id_t y_id;
  isa_pkg::greg_id_t z_id;
  isa_pkg::greg_id_t xa_id;
  isa_pkg::preg_id_t pid;
  ctrl_pkg::sext_e   sext;
  logic              reg_id_sel;
  logic              pset;
  logic              p_guard;

  assign opcode = isa_pkg::opcode_e'(inst[isa_pkg::OPC_LSB +: $bits(isa_pkg::opcode_e)]);
  assign z_id   = inst[isa_pkg::Z_LSB +: $bits(isa_pkg::greg_id_t)];
  assign y_id   = inst[isa_pkg::Y_LSB +: $bits(isa_pkg::greg_id_t)];
  assign xa_id  = inst[isa_pkg::XA_LSB +: $bits(isa_pkg::greg_id_t)];
  assign pid    = inst[isa_pkg::PID_LSB +: $bits(isa_pkg::preg_id_t)];
  assign pset   = inst[isa_pkg::PSET_BIT];

  assign x_id  = reg_id_sel ? z_id : xa_id; // st reads its data reg via x
  assign rz_id = z_id;
  assign pval  = pset ? p_guard : 1'b1; // unguarded when pset clear

  control_decoder u_ctrl (
    .opcode     (opcode),
    .alu_op     (alu_op),
    .sext       (sext),
    .src2_imm   (src2_imm),
    .alu_int    (alu_int),
    .reg_id_sel (reg_id_sel),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .wb_mem     (wb_mem),
    .wb_pred    (wb_pred),
    .wb_greg    (wb_greg)
  );

  reg_file #(.DATA_W(32), .DEPTH(16)) u_greg (
    .clk     (clk),
    .rst     (rst),
    .we      (greg_we),
    .ra      (x_id),
    .rb      (y_id),
    .rc      (4'd0),
    .wa      (greg_wid),
    .wdata   (greg_wdata),
    .rdata_a (rx),
    .rdata_b (ry),
    .rdata_c ()
  );

  reg_file #(.DATA_W(1), .DEPTH(4)) u_preg (
    .clk     (clk),
    .rst     (rst),
    .we      (preg_we),
    .ra      (x_id[1:0]),
    .rb      (y_id[1:0]),
    .rc      (pid), // guard predicate
    .wa      (preg_wid),
    .wdata   (preg_wdata),
    .rdata_a (px),
    .rdata_b (py),
    .rdata_c (p_guard)
  );

  imm_extend u_imm (
    .sext  (sext),
    .field (inst[22:0]),
    .imm   (imm)
  );

endmodule

`default_nettype wire

// File: imm_extend.sv
`default_nettype none

module imm_extend (
  input  wire ctrl_pkg::sext_e sext,
  input  wire [22:0]           field,
  output isa_pkg::word_t       imm
);

  always_comb
  begin
    case (sext)
      ctrl_pkg::SEXT_15:
      begin
        imm = {{17{field[14]}}, field[14:0]}; // ld/st and imm arith
      end
      ctrl_pkg::SEXT_23:
      begin
        imm = {{9{field[22]}}, field[22:0]};
      end
      ctrl_pkg::SEXT_19:
      begin
        imm = {{13{field[18]}}, field[18:0]}; // ldi
      end
      default:
      begin
        imm = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: isa_pkg.sv
`default_nettype none

package isa_pkg;

  typedef logic [31:0] word_t;

  typedef logic [3:0] greg_id_t;
  typedef logic [1:0] preg_id_t;

  typedef enum logic [5:0] {
    NEG    = 6'h05,
    NOT    = 6'h06,
    AND    = 6'h07,
    OR     = 6'h08,
    XOR    = 6'h09,
    ADD    = 6'h0a,
    SUB    = 6'h0b,
    MUL    = 6'h0c,
    DIV    = 6'h0d,
    MOD    = 6'h0e,
    SHL    = 6'h0f,
    SHR    = 6'h10,
    ANDI   = 6'h11,
    ORI    = 6'h12,
    XORI   = 6'h13,
    ADDI   = 6'h14,
    SUBI   = 6'h15,
    MULI   = 6'h16,
    DIVI   = 6'h17,
    MODI   = 6'h18,
    SHLI   = 6'h19,
    SHRI   = 6'h1a,
    LD     = 6'h23,
    ST     = 6'h24,
    LDI    = 6'h25,
    RTOP   = 6'h26,
    ANDP   = 6'h27,
    ORP    = 6'h28,
    XORP   = 6'h29,
    NOTP   = 6'h2a,
    ISNEG  = 6'h2b,
    ISZERO = 6'h2c
  } opcode_e;

  // instruction field positions
  localparam int OPC_LSB  = 23;
  localparam int Z_LSB    = 19;
  localparam int Y_LSB    = 15;
  localparam int XA_LSB   = 11; // x for all but stores
  localparam int PID_LSB  = 29;
  localparam int PSET_BIT = 31; // guard enable

endpackage

`default_nettype wire

// File: reg_file.sv
`default_nettype none

module reg_file #(
  parameter int DATA_W = 32,
  parameter int DEPTH  = 16
) (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       we,
  input  wire [$clog2(DEPTH)-1:0]   ra,
  input  wire [$clog2(DEPTH)-1:0]   rb,
  input  wire [$clog2(DEPTH)-1:0]   rc,
  input  wire [$clog2(DEPTH)-1:0]   wa,
  input  wire [DATA_W-1:0]          wdata,
  output logic [DATA_W-1:0]         rdata_a,
  output logic [DATA_W-1:0]         rdata_b,
  output logic [DATA_W-1:0]         rdata_c
);

  logic [DATA_W-1:0] regs [DEPTH];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < DEPTH; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (we)
    begin
      regs[wa] <= wdata; // visible from next cycle, no bypass
    end
  end

  assign rdata_a = regs[ra];
  assign rdata_b = regs[rb];
  assign rdata_c = regs[rc];

endmodule

`default_nettype wire

// File: tb_decode_stage.sv
`default_nettype none

module tb_decode_stage;

  localparam int CLK_PERIOD = 8;
  localparam int CASE_WORDS = 16; // hex words per line of the cases file
  localparam int MAX_CASES  = 64;

  logic                 clk;
  logic                 rst;
  isa_pkg::word_t       inst;
  logic                 greg_we;
  isa_pkg::greg_id_t    greg_wid;
  isa_pkg::word_t       greg_wdata;
  logic                 preg_we;
  isa_pkg::preg_id_t    preg_wid;
  logic                 preg_wdata;
  isa_pkg::word_t       rx;
  isa_pkg::word_t       ry;
  logic                 px;
  logic                 py;
  logic                 pval;
  isa_pkg::greg_id_t    rz_id;
  isa_pkg::word_t       imm;
  ctrl_pkg::alu_op_e    alu_op;
  logic                 src2_imm;
  logic                 alu_int;
  logic                 mem_read;
  logic                 mem_write;
  logic                 wb_mem;
  logic                 wb_pred;
  logic                 wb_greg;

  isa_pkg::word_t case_mem [MAX_CASES * CASE_WORDS];
  int             num_cases;
  int             cur_case;
  int             errors;
  bit             loaded;

  decode_stage uut (
    .clk        (clk),
    .rst        (rst),
    .inst       (inst),
    .greg_we    (greg_we),
    .greg_wid   (greg_wid),
    .greg_wdata (greg_wdata),
    .preg_we    (preg_we),
    .preg_wid   (preg_wid),
    .preg_wdata (preg_wdata),
    .rx         (rx),
    .ry         (ry),
    .px         (px),
    .py         (py),
    .pval       (pval),
    .rz_id      (rz_id),
    .imm        (imm),
    .alu_op     (alu_op),
    .src2_imm   (src2_imm),
    .alu_int    (alu_int),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .wb_mem     (wb_mem),
    .wb_pred    (wb_pred),
    .wb_greg    (wb_greg)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_alu_op(input string name, input ctrl_pkg::alu_op_e got,
                              input ctrl_pkg::alu_op_e exp);
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] case %0d %s got %h expected %h", cur_case, name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input isa_pkg::word_t got,
                            input isa_pkg::word_t exp);
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] case %0d %s got %h expected %h", cur_case, name, got, exp);
    end
  endtask

  task automatic check_reg_id(input string name, input isa_pkg::greg_id_t got,
                              input isa_pkg::greg_id_t exp);
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] case %0d %s got %h expected %h", cur_case, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] case %0d %s got %h expected %h", cur_case, name, got, exp);
    end
  endtask

  task automatic apply_stimulus(input int k);
    int b;
    b = k * CASE_WORDS;
    inst       = case_mem[b];
    greg_we    = case_mem[b + 1][0];
    greg_wid   = case_mem[b + 2][3:0];
    greg_wdata = case_mem[b + 3];
    preg_we    = case_mem[b + 4][0];
    preg_wid   = case_mem[b + 5][1:0];
    preg_wdata = case_mem[b + 6][0];
    rst        = case_mem[b + 7][0];
  endtask

  task automatic check_outputs(input int k);
    int         b;
    logic [6:0] flags;
    b = k * CASE_WORDS;
    flags = case_mem[b + 9][6:0];
    check_alu_op("alu_op", alu_op, ctrl_pkg::alu_op_e'(case_mem[b + 8][3:0]));
    check_bit("src2_imm", src2_imm, flags[6]);
    check_bit("alu_int", alu_int, flags[5]);
    check_bit("mem_read", mem_read, flags[4]);
    check_bit("mem_write", mem_write, flags[3]);
    check_bit("wb_mem", wb_mem, flags[2]);
    check_bit("wb_pred", wb_pred, flags[1]);
    check_bit("wb_greg", wb_greg, flags[0]);
    check_word("imm", imm, case_mem[b + 10]);
    check_word("rx", rx, case_mem[b + 11]);
    check_word("ry", ry, case_mem[b + 12]);
    check_bit("px", px, case_mem[b + 13][0]);
    check_bit("py", py, case_mem[b + 14][0]);
    check_bit("pval", pval, case_mem[b + 15][0]);
    check_reg_id("rz_id", rz_id, case_mem[b][22:19]); // z field of the driven inst
  endtask

  initial
  begin
    rst        = 1'b1;
    inst       = '0;
    greg_we    = 1'b0;
    greg_wid   = '0;
    greg_wdata = '0;
    preg_we    = 1'b0;
    preg_wid   = '0;
    preg_wdata = 1'b0;
    errors     = 0;
    cur_case   = 0;
    loaded     = 1'b0;
    for (int i = 0; i < MAX_CASES * CASE_WORDS; i++)
    begin
      case_mem[i] = {16'hbad0, 16'(i)}; // unused slots never hold 0 or 1
    end
    $readmemh("decode_cases.mem", case_mem);
    num_cases = 0;
    while (num_cases < MAX_CASES && case_mem[num_cases * CASE_WORDS + 1] < 32'd2)
    begin
      num_cases++;
    end
    loaded = 1'b1;
    if (num_cases == 0)
    begin
      errors++;
      $display("no test cases could be read from decode_cases.mem");
    end
    repeat (3) @(posedge clk);
    for (int k = 0; k < num_cases; k++)
    begin
      @(negedge clk);
      cur_case = k;
      apply_stimulus(k);
      #(CLK_PERIOD / 2 - 1); // just before the write edge
      check_outputs(k);
    end
    $display("cases run: %0d, errors: %0d", num_cases, errors);
    if (errors == 0)
    begin
      $display("Test passed");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog
  initial
  begin
    wait (loaded);
    #((num_cases + 4) * CLK_PERIOD * 4);
    $display("timeout: the case loop did not finish in the expected time");
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire
